//--- design/dbg_event_pkg.sv
// Widths are fixed for this subsystem; a change here must keep EVENT_NUM_WORDS > MAX_PAYLOAD
package dbg_event_pkg;

  ////////////////////////////////////////////////////////////
  // Sizing
  ////////////////////////////////////////////////////////////

  // Debug interconnect flit width
  localparam int FLIT_WIDTH       = 16;
  // Raw trace event width
  localparam int EVENT_DATA_WIDTH = 40;
  // Payload words per event, rounded up to whole flits
  localparam int EVENT_NUM_WORDS  = (EVENT_DATA_WIDTH + FLIT_WIDTH - 1) / FLIT_WIDTH;
  // Packet length in flits, the three header flits included
  localparam int MAX_PKT_LEN      = 5;
  localparam int MAX_PAYLOAD      = MAX_PKT_LEN - 3;
  // Width of the core's word request index
  localparam int WORD_IDX_WIDTH   = $clog2(EVENT_NUM_WORDS);
  // Saturating drop counter width, one payload flit
  localparam int OVF_COUNT_WIDTH  = 16;

  ////////////////////////////////////////////////////////////
  // Header flit fields
  ////////////////////////////////////////////////////////////

  // TYPE lives in bits 15:14, TYPE_SUB in bits 13:10
  localparam logic [1:0] TYPE_EVENT   = 2'd2;
  localparam logic [3:0] SUB_FIRST    = 4'd0;
  localparam logic [3:0] SUB_CONT     = 4'd1;
  localparam logic [3:0] SUB_OVERFLOW = 4'd5;

  ////////////////////////////////////////////////////////////
  // Packetizer FSM encoding
  ////////////////////////////////////////////////////////////

  localparam logic [2:0] ST_IDLE    = 3'd0;
  localparam logic [2:0] ST_DEST    = 3'd1;
  localparam logic [2:0] ST_SRC     = 3'd2;
  localparam logic [2:0] ST_HDR     = 3'd3;
  localparam logic [2:0] ST_PAYLOAD = 3'd4;

endpackage

//--- design/dbg_event_capture.sv
// One-entry event holder; drops beyond one held event are counted (saturating) and reported later
module dbg_event_capture
  import dbg_event_pkg::*;
(
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        trace_valid,
  input  logic [EVENT_DATA_WIDTH-1:0] trace_data,
  input  logic                        event_consumed,
  output logic                        event_available,
  output logic                        overflow,
  output logic [EVENT_DATA_WIDTH-1:0] event_data
);

  // Holder for the one trace event waiting to be packetized
  logic                        held_valid;
  logic [EVENT_DATA_WIDTH-1:0] held_data;
  // Overflow request, presented ahead of the holder
  logic                        ovf_pending;
  logic [OVF_COUNT_WIDTH-1:0]  ovf_count;
  // Events lost since the last report
  logic [OVF_COUNT_WIDTH-1:0]  drop_cnt;

  logic held_free;
  logic ovf_free;
  logic holder_load;
  logic drop;

  // A consume pulse belongs to whichever request is presented
  assign held_free   = event_consumed & ~ovf_pending;
  assign ovf_free    = event_consumed & ovf_pending;
  // Load into an empty holder or into the slot being freed this cycle
  assign holder_load = trace_valid & (~held_valid | held_free);
  assign drop        = trace_valid & held_valid & ~held_free;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      held_valid  <= 1'b0;
      ovf_pending <= 1'b0;
      drop_cnt    <= '0;
    end else begin
      if (holder_load) begin
        held_valid <= 1'b1;
      end else if (held_free) begin
        held_valid <= 1'b0;
      end
      // Report drops right after the event that was sent
      if (ovf_free) begin
        ovf_pending <= 1'b0;
      end else if (held_free && (drop_cnt != '0)) begin
        ovf_pending <= 1'b1;
      end
      if (held_free) begin
        drop_cnt <= '0;
      end else if (drop && (drop_cnt != '1)) begin
        drop_cnt <= drop_cnt + 1'b1;
      end
    end
  end

  // Payload registers
  always_ff @(posedge clk) begin
    if (holder_load) begin
      held_data <= trace_data;
    end
    if (held_free) begin
      ovf_count <= drop_cnt;
    end
  end

  assign event_available = held_valid | ovf_pending;
  assign overflow        = ovf_pending;
  // Overflow count rides in the low bits of the event word
  assign event_data      = ovf_pending ?
                           {{(EVENT_DATA_WIDTH - OVF_COUNT_WIDTH){1'b0}}, ovf_count} :
                           held_data;

  // Request must not move under the packetizer until it is consumed
  a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (event_available && !event_consumed) |=>
      (event_available && $stable(event_data) && $stable(overflow)));

  // Core may only consume a request that is presented
  a_consume_avail: assert property (@(posedge clk) disable iff (!rst_n)
    event_consumed |-> event_available);

endmodule

//--- design/dbg_event_packetization.sv
// EVENT packets only; request inputs must stay stable from event_available until event_consumed
module dbg_event_packetization
  import dbg_event_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic [FLIT_WIDTH-1:0]     id,
  input  logic [FLIT_WIDTH-1:0]     dest,
  input  logic                      overflow,
  input  logic                      event_available,
  input  logic [FLIT_WIDTH-1:0]     data_word,
  input  logic                      debug_out_ready,
  output logic                      event_consumed,
  output logic [WORD_IDX_WIDTH-1:0] data_req_idx,
  output logic                      debug_out_valid,
  output logic [FLIT_WIDTH-1:0]     debug_out_data,
  output logic                      debug_out_last
);

  logic [2:0]                       state;
  // Flits already sent in the current packet
  logic [$clog2(MAX_PKT_LEN+1)-1:0] pkt_flit;
  // Word of the event, counted across packets
  logic [WORD_IDX_WIDTH-1:0]        word_idx;
  // Set once the first packet of an event is out
  logic                             cont;

  logic            xfer;
  logic            last_word;
  logic            pkt_full;
  logic            req_done;
  logic [3:0]      type_sub;

  assign xfer      = debug_out_valid & debug_out_ready;
  assign last_word = (word_idx == WORD_IDX_WIDTH'(EVENT_NUM_WORDS - 1));
  // Payload slot used by the current flit fills the packet
  assign pkt_full  = (pkt_flit == ($clog2(MAX_PKT_LEN+1))'(MAX_PKT_LEN - 1));
  // Overflow carries a single payload flit
  assign req_done  = overflow | last_word;

  assign type_sub  = overflow ? SUB_OVERFLOW : (cont ? SUB_CONT : SUB_FIRST);

  ////////////////////////////////////////////////////////////
  // Flit output
  ////////////////////////////////////////////////////////////

  assign debug_out_valid = (state != ST_IDLE);
  assign data_req_idx    = word_idx;

  always_comb begin
    case (state)
      ST_DEST:    debug_out_data = dest;
      ST_SRC:     debug_out_data = id;
      // Header built from fields, unused bits zero
      ST_HDR:     debug_out_data = {TYPE_EVENT, type_sub, 10'b0};
      ST_PAYLOAD: debug_out_data = data_word;
      default:    debug_out_data = '0;
    endcase
  end

  assign debug_out_last = (state == ST_PAYLOAD) & (req_done | pkt_full);
  assign event_consumed = xfer & (state == ST_PAYLOAD) & req_done;

  ////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= ST_IDLE;
      pkt_flit <= '0;
      word_idx <= '0;
      cont     <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          // New request starts with word 0 and TYPE_SUB 0
          if (event_available) begin
            state    <= ST_DEST;
            pkt_flit <= '0;
            word_idx <= '0;
            cont     <= 1'b0;
          end
        end
        ST_DEST: begin
          if (xfer) begin
            state    <= ST_SRC;
            pkt_flit <= pkt_flit + 1'b1;
          end
        end
        ST_SRC: begin
          if (xfer) begin
            state    <= ST_HDR;
            pkt_flit <= pkt_flit + 1'b1;
          end
        end
        ST_HDR: begin
          if (xfer) begin
            state    <= ST_PAYLOAD;
            pkt_flit <= pkt_flit + 1'b1;
          end
        end
        ST_PAYLOAD: begin
          if (xfer) begin
            if (req_done) begin
              state    <= ST_IDLE;
              pkt_flit <= '0;
            end else if (pkt_full) begin
              // Reopen straight away as a continuation packet
              state    <= ST_DEST;
              pkt_flit <= '0;
              cont     <= 1'b1;
              word_idx <= word_idx + 1'b1;
            end else begin
              pkt_flit <= pkt_flit + 1'b1;
              word_idx <= word_idx + 1'b1;
            end
          end
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  // Flit holds under back-pressure, which relies on the request staying put
  a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (debug_out_valid && !debug_out_ready) |=>
      (debug_out_valid && $stable(debug_out_data) && $stable(debug_out_last)));

  // Last is always reached before the length limit
  a_pkt_len: assert property (@(posedge clk) disable iff (!rst_n)
    (xfer && !debug_out_last) |=> (pkt_flit < MAX_PKT_LEN));

endmodule

//--- design/dbg_event_packetization_fixedwidth.sv
// Fixed 40-bit events cut into 16-bit words; last word zero-padded, index beyond the end reads 0
module dbg_event_packetization_fixedwidth
  import dbg_event_pkg::*;
(
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic [FLIT_WIDTH-1:0]       id,
  input  logic [FLIT_WIDTH-1:0]       dest,
  input  logic                        overflow,
  input  logic                        event_available,
  input  logic [EVENT_DATA_WIDTH-1:0] event_data,
  input  logic                        debug_out_ready,
  output logic                        event_consumed,
  output logic                        debug_out_valid,
  output logic [FLIT_WIDTH-1:0]       debug_out_data,
  output logic                        debug_out_last
);

  logic [WORD_IDX_WIDTH-1:0]             data_req_idx;
  logic [FLIT_WIDTH-1:0]                 data_word;
  // Event widened to whole words, zeros on top
  logic [EVENT_NUM_WORDS*FLIT_WIDTH-1:0] event_padded;

  assign event_padded = {{(EVENT_NUM_WORDS*FLIT_WIDTH - EVENT_DATA_WIDTH){1'b0}}, event_data};

  // Word k is bits 16k+15 down to 16k
  always_comb begin
    data_word = '0;
    for (int k = 0; k < EVENT_NUM_WORDS; k++) begin
      if (data_req_idx == WORD_IDX_WIDTH'(k)) begin
        data_word = event_padded[k*FLIT_WIDTH +: FLIT_WIDTH];
      end
    end
  end

  dbg_event_packetization u_packetization (
    .clk             (clk),
    .rst_n           (rst_n),
    .id              (id),
    .dest            (dest),
    .overflow        (overflow),
    .event_available (event_available),
    .data_word       (data_word),
    .debug_out_ready (debug_out_ready),
    .event_consumed  (event_consumed),
    .data_req_idx    (data_req_idx),
    .debug_out_valid (debug_out_valid),
    .debug_out_data  (debug_out_data),
    .debug_out_last  (debug_out_last)
  );

  // Core never walks past the event's words
  a_idx_range: assert property (@(posedge clk) disable iff (!rst_n)
    debug_out_valid |-> (data_req_idx < EVENT_NUM_WORDS));

endmodule

//--- design/dbg_event_top.sv
// Event packetizer only; id and dest must be held static while the block runs
module dbg_event_top
  import dbg_event_pkg::*;
(
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic [FLIT_WIDTH-1:0]       id,
  input  logic [FLIT_WIDTH-1:0]       dest,
  input  logic                        trace_valid,
  input  logic [EVENT_DATA_WIDTH-1:0] trace_data,
  input  logic                        debug_out_ready,
  output logic                        debug_out_valid,
  output logic [FLIT_WIDTH-1:0]       debug_out_data,
  output logic                        debug_out_last
);

  // Request handshake between capture and packetizer
  logic                        event_available;
  logic                        event_consumed;
  logic                        overflow;
  logic [EVENT_DATA_WIDTH-1:0] event_data;

  dbg_event_capture u_capture (
    .clk             (clk),
    .rst_n           (rst_n),
    .trace_valid     (trace_valid),
    .trace_data      (trace_data),
    .event_consumed  (event_consumed),
    .event_available (event_available),
    .overflow        (overflow),
    .event_data      (event_data)
  );

  dbg_event_packetization_fixedwidth u_packetizer (
    .clk             (clk),
    .rst_n           (rst_n),
    .id              (id),
    .dest            (dest),
    .overflow        (overflow),
    .event_available (event_available),
    .event_data      (event_data),
    .debug_out_ready (debug_out_ready),
    .event_consumed  (event_consumed),
    .debug_out_valid (debug_out_valid),
    .debug_out_data  (debug_out_data),
    .debug_out_last  (debug_out_last)
  );

endmodule

//--- verif/dbg_event_tb.sv
// Run from the project root so verif/dbg_event_vectors.txt opens; expected flits assume id 00a5, dest 0c01
module dbg_event_tb
  import dbg_event_pkg::*;
();

  logic                        clk;
  logic                        rst_n;
  logic [FLIT_WIDTH-1:0]       id;
  logic [FLIT_WIDTH-1:0]       dest;
  logic                        trace_valid;
  logic [EVENT_DATA_WIDTH-1:0] trace_data;
  logic                        debug_out_ready;
  logic                        debug_out_valid;
  logic [FLIT_WIDTH-1:0]       debug_out_data;
  logic                        debug_out_last;

  // Transferred flits as {last, data}, oldest first
  logic [FLIT_WIDTH:0]   flit_q[$];
  // Flit seen stalled on the previous edge
  logic                  stall_seen;
  logic [FLIT_WIDTH-1:0] stall_data;
  bit                    random_ready;
  integer                seed = 32'h2cd8b4f4;

  dbg_event_top DUT (
    .clk             (clk),
    .rst_n           (rst_n),
    .id              (id),
    .dest            (dest),
    .trace_valid     (trace_valid),
    .trace_data      (trace_data),
    .debug_out_ready (debug_out_ready),
    .debug_out_valid (debug_out_valid),
    .debug_out_data  (debug_out_data),
    .debug_out_last  (debug_out_last)
  );

  always #5 clk = ~clk;

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  task automatic stop_run(input string reason);
    $display("%s", reason);
    $display("*** FAILED ***");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      stop_run($sformatf("Fail %s actual 0x%h expected 0x%h", name, actual, expected));
    end
  endtask

  // One-cycle strobe, then gap idle cycles
  task automatic send_trace(input logic [EVENT_DATA_WIDTH-1:0] data, input int gap);
    trace_valid = 1'b1;
    trace_data  = data;
    @(negedge clk);
    trace_valid = 1'b0;
    repeat (gap) @(negedge clk);
  endtask

  task automatic idle_check(input int cycles);
    repeat (cycles) begin
      @(negedge clk);
      check_value("debug_out_valid", debug_out_valid, 0);
    end
  endtask

  // Next transferred flit, waited for at most 200 cycles
  task automatic expect_flit(input logic [FLIT_WIDTH-1:0] flit, input logic last);
    int                  waited;
    logic [FLIT_WIDTH:0] got;
    waited = 0;
    while (flit_q.size() == 0) begin
      if (waited == 200) begin
        stop_run("No flit arrived on the debug output within 200 cycles");
      end
      @(negedge clk);
      waited++;
    end
    got = flit_q.pop_front();
    check_value("debug_out_data", got[FLIT_WIDTH-1:0], flit);
    check_value("debug_out_last", got[FLIT_WIDTH], last);
  endtask

  ////////////////////////////////////////////////////////////
  // Ready driver and flit monitor
  ////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    debug_out_ready = random_ready ? $random(seed) : 1'b1;
  end

  always @(posedge clk) begin
    if (rst_n) begin
      // Stalled flit must still be there, unchanged
      if (stall_seen) begin
        check_value("debug_out_valid", debug_out_valid, 1);
        check_value("debug_out_data", debug_out_data, stall_data);
      end
      stall_seen = debug_out_valid & ~debug_out_ready;
      stall_data = debug_out_data;
      if (debug_out_valid && debug_out_ready) begin
        flit_q.push_back({debug_out_last, debug_out_data});
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Vector playback
  ////////////////////////////////////////////////////////////

  initial begin : main_flow
    int                          fd;
    int                          code;
    int                          arg;
    logic [63:0]                 kind;
    logic [1023:0]               rest;
    logic [EVENT_DATA_WIDTH-1:0] data;
    clk             = 1'b0;
    rst_n           = 1'b0;
    id              = 16'h00a5;
    dest            = 16'h0c01;
    trace_valid     = 1'b0;
    trace_data      = '0;
    debug_out_ready = 1'b1;
    random_ready    = 1'b0;
    stall_seen      = 1'b0;
    stall_data      = '0;
    fd = $fopen("verif/dbg_event_vectors.txt", "r");
    if (fd == 0) begin
      stop_run("Could not open the vectors file verif/dbg_event_vectors.txt");
    end
    repeat (4) @(negedge clk);
    rst_n = 1'b1;
    while ($fscanf(fd, "%s", kind) == 1) begin
      case (kind)
        "#": code = $fgets(rest, fd);
        "I": begin
          code = $fscanf(fd, "%d", arg);
          if (code != 1) begin
            stop_run("An idle record in the vectors file is malformed");
          end
          idle_check(arg);
        end
        "R": begin
          code = $fscanf(fd, "%d", arg);
          if (code != 1) begin
            stop_run("A ready record in the vectors file is malformed");
          end
          random_ready = arg[0];
        end
        "T": begin
          code = $fscanf(fd, "%h %d", data, arg);
          if (code != 2) begin
            stop_run("A trace record in the vectors file is malformed");
          end
          send_trace(data, arg);
        end
        "E": begin
          code = $fscanf(fd, "%h %d", data, arg);
          if (code != 2) begin
            stop_run("An expected flit record in the vectors file is malformed");
          end
          expect_flit(data[FLIT_WIDTH-1:0], arg[0]);
        end
        default: stop_run("The vectors file holds a record of unknown type");
      endcase
    end
    $fclose(fd);
    // Nothing beyond the listed flits may come out
    repeat (20) @(negedge clk);
    check_value("extra flit count", flit_q.size(), 0);
    $display("*** PASSED ***");
    $finish;
  end

endmodule

//--- verif/dbg_event_vectors.txt
# I idle_cycles | T event_hex gap_cycles | R random_ready | E flit_hex last
# Expected flits assume dest 0c01 and id 00a5
I 20
T ff12345678 0
T 1111111111 0
T 2222222222 0
E 0c01 0
E 00a5 0
E 8000 0
E 5678 0
E 1234 1
E 0c01 0
E 00a5 0
E 8400 0
E 00ff 1
E 0c01 0
E 00a5 0
E 9400 0
E 0002 1
R 1
T ffc3a55a0f 0
E 0c01 0
E 00a5 0
E 8000 0
E 5a0f 0
E c3a5 1
E 0c01 0
E 00a5 0
E 8400 0
E 00ff 1

//--- dbg_event.f
design/dbg_event_pkg.sv
design/dbg_event_capture.sv
design/dbg_event_packetization.sv
design/dbg_event_packetization_fixedwidth.sv
design/dbg_event_top.sv
verif/dbg_event_tb.sv
